// ==== logic/sdram_pkg.sv ====
// ######################################
// SDRAM bus definitions
// Port widths shared by the ROM readers and the download path
// ######################################

package sdram_pkg;

    // Word address into the 16-bit wide SDRAM
    parameter int SDRAM_AW = 22;

    // Read burst with the addressed word low and the next word high
    parameter int SDRAM_DW = 32;

    // Download port
    parameter int PROG_DW  = 8;     // One byte per ioctl_wr
    parameter int IOCTL_AW = 25;    // Byte address

endpackage

// ==== logic/rom_map_pkg.sv ====
// ######################################
// ROM memory map
// Region offsets and client address widths in SDRAM
// ######################################

package rom_map_pkg;

    // Region offsets in SDRAM words
    parameter logic [sdram_pkg::SDRAM_AW-1:0] CPU_OFFSET  = 22'h00_0000;
    parameter logic [sdram_pkg::SDRAM_AW-1:0] CHAR_OFFSET = 22'h02_0000;
    parameter logic [sdram_pkg::SDRAM_AW-1:0] MAP_OFFSET  = 22'h04_4000;

    // Object tiles sit between char and map and are interleaved on load
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_START   = 22'h02_4000;
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_END     = 22'h04_3FFF;

    // Client address widths
    parameter int CHAR_AW = 14;     // Words
    parameter int MAP_AW  = 14;     // Words
    parameter int CPU_AW  = 18;     // Bytes

    // Char, map and main CPU
    parameter int NSLOT = 3;

endpackage

// ==== logic/rom_slot.sv ====
// ######################################
// ROM client slot
// One 32-bit line cache in front of the shared SDRAM read port
// ######################################

module rom_slot #(
    parameter int  AW        = 14,
    parameter type payload_t = logic [15:0]
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           downloading,
    input  logic                           cs,
    input  logic [AW-1:0]                  addr,
    output payload_t                       data,
    output logic                           ok,
    output logic                           req,
    output logic [sdram_pkg::SDRAM_AW-1:0] req_addr,
    input  logic                           grant_done,
    input  logic [sdram_pkg::SDRAM_DW-1:0] fill_data
);

    localparam int SAW       = sdram_pkg::SDRAM_AW;
    localparam int HW        = sdram_pkg::SDRAM_DW / 2;
    localparam bit BYTE_MODE = ($bits(payload_t) == 8);

    logic [sdram_pkg::SDRAM_DW-1:0] line;
    logic [sdram_pkg::SDRAM_DW-1:0] src_line;
    logic [SAW-1:0]                 tag;
    logic [SAW-1:0]                 src_tag;
    logic [SAW-1:0]                 src_next;
    logic [SAW-1:0]                 word_addr;
    logic                           valid;
    logic                           src_valid;
    logic                           src_hit;
    logic                           upper;
    logic [HW-1:0]                  half_word;
    logic [HW-1:0]                  rd_word;

    // Byte clients drop the byte select bit
    assign word_addr = BYTE_MODE ? SAW'(addr >> 1) : SAW'(addr);

    // A line arriving now is usable in the same cycle
    assign src_line  = grant_done ? fill_data : line;
    assign src_tag   = grant_done ? req_addr  : tag;
    assign src_valid = grant_done | valid;
    assign src_next  = src_tag + 1'b1;
    assign src_hit   = src_valid && (word_addr == src_tag || word_addr == src_next);

    assign upper     = word_addr != src_tag;   // Second word of the line
    assign half_word = upper ? src_line[2*HW-1:HW] : src_line[HW-1:0];

    // Even byte sits in the low half of the word
    assign rd_word = BYTE_MODE ? {8'h00, addr[0] ? half_word[15:8] : half_word[7:0]}
                               : half_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
            ok    <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (grant_done) begin
                valid <= ~downloading;
                req   <= 1'b0;
            end
            if (downloading)
                valid <= 1'b0;      // SDRAM contents are changing
            ok <= cs & src_hit & ~downloading;
            // New miss, or a fill that no longer matches addr
            if (cs && !src_hit && !downloading && (!req || grant_done)) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_done) begin
            line <= fill_data;
            tag  <= req_addr;
        end
        if (cs && !src_hit && !downloading && (!req || grant_done))
            req_addr <= word_addr;
        if (src_hit)
            data <= payload_t'(rd_word);
    end

endmodule

// ==== logic/slot_arbiter.sv ====
// ######################################
// Slot arbiter
// Round-robin access to the SDRAM read port with region offsets
// ######################################

module slot_arbiter #(
    parameter int NSLOT = 3,
    parameter logic [NSLOT-1:0][sdram_pkg::SDRAM_AW-1:0] OFFSETS = '0
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      downloading,
    input  logic [NSLOT-1:0]                          req,
    input  logic [NSLOT-1:0][sdram_pkg::SDRAM_AW-1:0] req_addr,
    output logic [NSLOT-1:0]                          grant_done,
    output logic [sdram_pkg::SDRAM_DW-1:0]            fill_data,
    output logic                                      sdram_req,
    output logic [sdram_pkg::SDRAM_AW-1:0]            sdram_addr,
    input  logic                                      sdram_ack,
    input  logic                                      data_rdy,
    input  logic [sdram_pkg::SDRAM_DW-1:0]            data_read
);

    localparam int PW = (NSLOT > 1) ? $clog2(NSLOT) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,     // sdram_req held until accepted
        ST_DATA     // Waiting for data_rdy
    } state_t;

    state_t        state;
    logic [PW-1:0] last;    // Slot granted last and the one being served
    logic [PW-1:0] pick;
    logic          found;

    // Search starts right after the last granted slot
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = last;
        for (int i = 1; i <= NSLOT; i++) begin
            cand = int'(last) + i;
            if (cand >= NSLOT)
                cand = cand - NSLOT;
            if (!found && req[cand]) begin
                found = 1'b1;
                pick  = PW'(cand);
            end
        end
    end

    // Data goes to every slot but only the served one sees its strobe
    always_comb begin
        grant_done = '0;
        if (state == ST_DATA && data_rdy)
            grant_done[last] = 1'b1;
    end

    assign fill_data = data_read;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            last      <= PW'(NSLOT - 1);   // Slot 0 goes first
        end else begin
            case (state)
                ST_IDLE: begin
                    if (found && !downloading) begin
                        sdram_req <= 1'b1;
                        last      <= pick;
                        state     <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (downloading) begin
                        // Withdraw while the slot keeps its request
                        sdram_req <= 1'b0;
                        state     <= ST_IDLE;
                    end else if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && found && !downloading)
            sdram_addr <= req_addr[pick] + OFFSETS[pick];
    end

endmodule

// ==== logic/rom_dwnld.sv ====
// ######################################
// ROM download formatter
// Byte writes to masked SDRAM words with object tiles interleaved
// ######################################

module rom_dwnld #(
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_START = '0,
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_END   = '0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [sdram_pkg::IOCTL_AW-1:0]  ioctl_addr,
    input  logic [sdram_pkg::PROG_DW-1:0]   ioctl_data,
    input  logic                            ioctl_wr,
    input  logic                            sdram_ack,
    output logic [sdram_pkg::SDRAM_AW-1:0]  prog_addr,
    output logic [2*sdram_pkg::PROG_DW-1:0] prog_data,
    output logic [1:0]                      prog_mask,
    output logic                            prog_we
);

    localparam int SAW = sdram_pkg::SDRAM_AW;

    logic [SAW-1:0] word;
    logic [SAW-1:0] word_ilv;
    logic           in_obj;

    assign word   = SAW'(ioctl_addr >> 1);
    assign in_obj = (word >= OBJ_START) && (word <= OBJ_END);

    // Board layout of the object ROMs
    assign word_ilv = {word[SAW-1:6], word[4:1], word[5], word[0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (prog_we && sdram_ack) begin
            prog_we <= 1'b0;
        end else if (ioctl_wr) begin
            prog_we <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_addr <= in_obj ? word_ilv : word;
            prog_data <= {ioctl_data, ioctl_data};          // Mask picks the half
            prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;     // Even byte is low
        end
    end

endmodule

// ==== logic/rom_sub.sv ====
// ######################################
// ROM subsystem top level
// Three client slots sharing one SDRAM, plus the download path
// ######################################

module rom_sub #(
    parameter logic [sdram_pkg::SDRAM_AW-1:0] CHAR_OFFSET = rom_map_pkg::CHAR_OFFSET,
    parameter logic [sdram_pkg::SDRAM_AW-1:0] MAP_OFFSET  = rom_map_pkg::MAP_OFFSET,
    parameter logic [sdram_pkg::SDRAM_AW-1:0] CPU_OFFSET  = rom_map_pkg::CPU_OFFSET,
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_START   = rom_map_pkg::OBJ_START,
    parameter logic [sdram_pkg::SDRAM_AW-1:0] OBJ_END     = rom_map_pkg::OBJ_END,
    parameter int CHAR_AW = rom_map_pkg::CHAR_AW,
    parameter int MAP_AW  = rom_map_pkg::MAP_AW,
    parameter int CPU_AW  = rom_map_pkg::CPU_AW
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            downloading,
    // Char tiles
    input  logic                            char_cs,
    input  logic [CHAR_AW-1:0]              char_addr,
    output logic [15:0]                     char_data,
    output logic                            char_ok,
    // Scroll map
    input  logic                            map_cs,
    input  logic [MAP_AW-1:0]               map_addr,
    output logic [15:0]                     map_data,
    output logic                            map_ok,
    // Main CPU
    input  logic                            cpu_cs,
    input  logic [CPU_AW-1:0]               cpu_addr,
    output logic [7:0]                      cpu_data,
    output logic                            cpu_ok,
    // SDRAM
    output logic                            sdram_req,
    output logic [sdram_pkg::SDRAM_AW-1:0]  sdram_addr,
    input  logic                            sdram_ack,
    input  logic                            data_rdy,
    input  logic [sdram_pkg::SDRAM_DW-1:0]  data_read,
    // ROM load
    input  logic [sdram_pkg::IOCTL_AW-1:0]  ioctl_addr,
    input  logic [sdram_pkg::PROG_DW-1:0]   ioctl_data,
    input  logic                            ioctl_wr,
    output logic [sdram_pkg::SDRAM_AW-1:0]  prog_addr,
    output logic [2*sdram_pkg::PROG_DW-1:0] prog_data,
    output logic [1:0]                      prog_mask,
    output logic                            prog_we
);

    localparam int NSLOT = rom_map_pkg::NSLOT;

    logic [NSLOT-1:0]                          slot_req;
    logic [NSLOT-1:0][sdram_pkg::SDRAM_AW-1:0] slot_addr;
    logic [NSLOT-1:0]                          slot_done;
    logic [sdram_pkg::SDRAM_DW-1:0]            fill_data;

    rom_slot #(
        .AW        ( CHAR_AW        ),
        .payload_t ( logic [15:0]   )
    ) u_char_slot (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .cs          ( char_cs      ),
        .addr        ( char_addr    ),
        .data        ( char_data    ),
        .ok          ( char_ok      ),
        .req         ( slot_req[0]  ),
        .req_addr    ( slot_addr[0] ),
        .grant_done  ( slot_done[0] ),
        .fill_data   ( fill_data    )
    );

    rom_slot #(
        .AW        ( MAP_AW         ),
        .payload_t ( logic [15:0]   )
    ) u_map_slot (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .cs          ( map_cs       ),
        .addr        ( map_addr     ),
        .data        ( map_data     ),
        .ok          ( map_ok       ),
        .req         ( slot_req[1]  ),
        .req_addr    ( slot_addr[1] ),
        .grant_done  ( slot_done[1] ),
        .fill_data   ( fill_data    )
    );

    rom_slot #(
        .AW        ( CPU_AW         ),
        .payload_t ( logic [7:0]    )
    ) u_cpu_slot (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .cs          ( cpu_cs       ),
        .addr        ( cpu_addr     ),
        .data        ( cpu_data     ),
        .ok          ( cpu_ok       ),
        .req         ( slot_req[2]  ),
        .req_addr    ( slot_addr[2] ),
        .grant_done  ( slot_done[2] ),
        .fill_data   ( fill_data    )
    );

    // Slot order is char, map, cpu
    slot_arbiter #(
        .NSLOT   ( NSLOT                                  ),
        .OFFSETS ( {CPU_OFFSET, MAP_OFFSET, CHAR_OFFSET}  )
    ) u_arbiter (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .downloading ( downloading  ),
        .req         ( slot_req     ),
        .req_addr    ( slot_addr    ),
        .grant_done  ( slot_done    ),
        .fill_data   ( fill_data    ),
        .sdram_req   ( sdram_req    ),
        .sdram_addr  ( sdram_addr   ),
        .sdram_ack   ( sdram_ack    ),
        .data_rdy    ( data_rdy     ),
        .data_read   ( data_read    )
    );

    rom_dwnld #(
        .OBJ_START ( OBJ_START ),
        .OBJ_END   ( OBJ_END   )
    ) u_dwnld (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_data ( ioctl_data ),
        .ioctl_wr   ( ioctl_wr   ),
        .sdram_ack  ( sdram_ack  ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    )
    );

endmodule

// ==== verification/sdram_model.sv ====
// ######################################
// Behavioral SDRAM
// Random ack and read latency and masked byte writes
// ######################################

module sdram_model (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            sdram_req,
    input  logic [sdram_pkg::SDRAM_AW-1:0]  sdram_addr,
    output logic                            sdram_ack,
    output logic                            data_rdy,
    output logic [sdram_pkg::SDRAM_DW-1:0]  data_read,
    input  logic                            prog_we,
    input  logic [sdram_pkg::SDRAM_AW-1:0]  prog_addr,
    input  logic [2*sdram_pkg::PROG_DW-1:0] prog_data,
    input  logic [1:0]                      prog_mask
);

    logic [15:0] mem [int];     // Only written words are stored
    int          seed = 75;

    // Power-up contents depend on every address bit
    function automatic logic [15:0] fill_word(input int a);
        logic [21:0] x;
        x = a[21:0];
        return x[15:0] ^ {x[21:16], x[21:12]} ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] read_word(input int a);
        if (mem.exists(a))
            return mem[a];
        return fill_word(a);
    endfunction

    initial begin
        int          delay;
        int          a;
        logic [15:0] w;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (reset) begin
                sdram_ack <= 1'b0;
                data_rdy  <= 1'b0;
            end else if (prog_we) begin
                a = int'(prog_addr);
                w = read_word(a);
                if (prog_mask[0]) w[7:0]  = prog_data[7:0];
                if (prog_mask[1]) w[15:8] = prog_data[15:8];
                mem[a] = w;
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
            end else if (sdram_req) begin
                delay = $random(seed) & 3;      // 0 to 3 cycles before ack
                repeat (delay) @(posedge clk);
                a = int'(sdram_addr);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                delay = $random(seed) & 3;      // data 1 to 4 cycles after ack
                repeat (delay) @(posedge clk);
                data_read <= {read_word(a + 1), read_word(a)};
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

endmodule

// ==== verification/tb_rom_sub.sv ====
// ######################################
// ROM subsystem testbench
// Download, random client reads, contention and invalidation
// ######################################

module tb_rom_sub;

    localparam int SAW = sdram_pkg::SDRAM_AW;
    localparam int CHAR_OFF = int'(rom_map_pkg::CHAR_OFFSET);
    localparam int MAP_OFF  = int'(rom_map_pkg::MAP_OFFSET);
    localparam int CPU_OFF  = int'(rom_map_pkg::CPU_OFFSET);
    localparam int OBJ_LO   = int'(rom_map_pkg::OBJ_START);
    localparam int OBJ_HI   = int'(rom_map_pkg::OBJ_END);

    logic clk = 1'b0;
    logic reset, downloading;
    logic char_cs, map_cs, cpu_cs;
    logic [rom_map_pkg::CHAR_AW-1:0] char_addr;
    logic [rom_map_pkg::MAP_AW-1:0]  map_addr;
    logic [rom_map_pkg::CPU_AW-1:0]  cpu_addr;
    logic [15:0] char_data, map_data;
    logic [7:0]  cpu_data;
    logic char_ok, map_ok, cpu_ok;
    logic sdram_req, sdram_ack, data_rdy;
    logic [SAW-1:0] sdram_addr;
    logic [sdram_pkg::SDRAM_DW-1:0] data_read;
    logic [sdram_pkg::IOCTL_AW-1:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic [SAW-1:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;

    logic [15:0] ref_mem [int];     // Expected SDRAM contents
    int          grants [$];        // Accepted read addresses, in order
    int          last_slot = 2;     // Slot 0 goes first after reset
    int          seed = 75;

    always #5 clk = ~clk;

    rom_sub i_rom_sub (.*);

    sdram_model u_sdram (.*);

    function automatic int slot_of(input int a);
        if (a >= MAP_OFF) return 1;
        if (a >= CHAR_OFF) return 0;
        return 2;
    endfunction

    always @(posedge clk) begin
        if (!reset && sdram_req && sdram_ack) begin
            grants.push_back(int'(sdram_addr));
            last_slot = slot_of(int'(sdram_addr));
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_run("Value mismatch");
        end
    endtask

    function automatic logic [15:0] ref_word(input int a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return u_sdram.fill_word(a);
    endfunction

    // Object tiles move bit 5 to bit 1 and bits 4..1 up by one
    function automatic int shuffle_obj(input int w);
        return (w & ~32'h3f) | (((w >> 5) & 1) << 1) | (((w >> 1) & 4'hf) << 2) | (w & 1);
    endfunction

    function automatic logic [15:0] expect_data(input int client, input int a);
        logic [15:0] w;
        if (client == 0) return ref_word(CHAR_OFF + a);
        if (client == 1) return ref_word(MAP_OFF + a);
        w = ref_word(CPU_OFF + (a >> 1));
        return (a & 1) ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
    endfunction

    task automatic write_byte(input int baddr, input logic [7:0] b);
        int          w;
        int          t;
        logic [15:0] mw;
        @(negedge clk);
        ioctl_addr = baddr[sdram_pkg::IOCTL_AW-1:0];
        ioctl_data = b;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        if (!prog_we) stop_run("prog_we did not rise after a download write");
        w = baddr >> 1;
        if (w >= OBJ_LO && w <= OBJ_HI) w = shuffle_obj(w);
        check("prog_addr", prog_addr, w);
        check("prog_mask", prog_mask, (baddr & 1) ? 2'b10 : 2'b01);
        check("prog_data", prog_data, {b, b});
        mw = ref_word(w);
        if (baddr & 1) mw[15:8] = b;
        else mw[7:0] = b;
        ref_mem[w] = mw;
        for (t = 0; t < 20 && prog_we; t++) begin
            check("sdram_req", sdram_req, 0);
            @(negedge clk);
        end
        if (prog_we) stop_run("prog_we was never acknowledged");
    endtask

    task automatic drive_client(input int client, input logic cs, input int a);
        case (client)
            0: begin
                char_cs   = cs;
                char_addr = a[13:0];
            end
            1: begin
                map_cs   = cs;
                map_addr = a[13:0];
            end
            default: begin
                cpu_cs   = cs;
                cpu_addr = a[17:0];
            end
        endcase
    endtask

    function automatic logic client_ok(input int client);
        return (client == 0) ? char_ok : (client == 1) ? map_ok : cpu_ok;
    endfunction

    function automatic logic [15:0] client_data(input int client);
        return (client == 0) ? char_data : (client == 1) ? map_data : {8'h00, cpu_data};
    endfunction

    // Reads on the listed clients at once with one address each
    task automatic read_clients(input logic [2:0] use_c, input int a0, input int a1, input int a2);
        logic [2:0] done;
        int         t;
        int         c;
        int         a [3];
        a[0] = a0;
        a[1] = a1;
        a[2] = a2;
        done = ~use_c;
        @(negedge clk);
        for (c = 0; c < 3; c++)
            if (use_c[c]) drive_client(c, 1'b1, a[c]);
        for (t = 0; t < 200 && done != 3'b111; t++) begin
            @(negedge clk);
            for (c = 0; c < 3; c++) begin
                if (!done[c] && client_ok(c)) begin
                    check($sformatf("data of client %0d", c), client_data(c), expect_data(c, a[c]));
                    done[c] = 1'b1;
                end
            end
        end
        if (done != 3'b111) stop_run("a client never saw ok after its read");
        for (c = 0; c < 3; c++) drive_client(c, 1'b0, a[c]);
    endtask

    initial begin
        int n;
        int i;
        int k;
        int prev;
        int a;
        reset       = 1'b1;
        downloading = 1'b0;
        char_cs     = 1'b0;
        map_cs      = 1'b0;
        cpu_cs      = 1'b0;
        char_addr   = '0;
        map_addr    = '0;
        cpu_addr    = '0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check("sdram_req", sdram_req, 0);
        check("prog_we", prog_we, 0);
        check("ok", {char_ok, map_ok, cpu_ok}, 0);

        // Download across all regions including the object range
        downloading = 1'b1;
        for (i = 0; i < 3; i++)
            drive_client(i, 1'b1, 4 * i + 2);   // Clients keep asking meanwhile
        for (i = 0; i < 60; i++) begin
            case (i % 4)
                0: a = CHAR_OFF + ($random(seed) & 'hff);
                1: a = MAP_OFF + ($random(seed) & 'hff);
                2: a = CPU_OFF + ($random(seed) & 'hff);
                default: a = OBJ_LO + ($random(seed) & 'h7f);
            endcase
            write_byte(2 * a + ($random(seed) & 1), 8'($random(seed)));
        end
        @(negedge clk);
        downloading = 1'b0;
        for (i = 0; i < 3; i++)
            drive_client(i, 1'b0, 0);

        // Each client misses once and then hits the line it filled
        a = $random(seed) & 'hfe;
        n = grants.size();
        read_clients(3'b001, a, 0, 0);
        read_clients(3'b001, a + 1, 0, 0);
        check("read count", grants.size(), n + 1);
        n = grants.size();
        read_clients(3'b010, 0, a, 0);
        read_clients(3'b010, 0, a + 1, 0);
        check("read count", grants.size(), n + 1);
        a = $random(seed) & 'h1fc;
        n = grants.size();
        for (k = 0; k < 4; k++) read_clients(3'b100, 0, 0, a + k);
        check("read count", grants.size(), n + 1);

        // One client at a time
        for (i = 0; i < 30; i++)
            read_clients(3'b001 << (i % 3), $random(seed) & 'h1ff, $random(seed) & 'h1ff,
                         $random(seed) & 'h3ff);

        // Contention on lines that no client holds yet
        for (i = 0; i < 10; i++) begin
            a = (i & 1) ? 0 : 'h2000;
            // A lone read first moves the round-robin start
            read_clients(3'b001 << (i % 3), a | 'h1000 | ($random(seed) & 'hffe),
                         a | 'h1000 | ($random(seed) & 'hffe),
                         (a << 4) | 'h10000 | ($random(seed) & 'hfffd));
            check("last granted slot", last_slot, i % 3);
            n = grants.size();
            prev = i % 3;
            read_clients(3'b111, a | ($random(seed) & 'hffe), a | ($random(seed) & 'hffe),
                         (a << 4) | ($random(seed) & 'hfffd));
            check("read count", grants.size(), n + 3);
            for (k = 0; k < 3; k++)
                check("granted slot", slot_of(grants[n + k]), (prev + 1 + k) % 3);
        end

        // Invalidation on a rewrite of a cached word
        a = $random(seed) & 'hff;
        read_clients(3'b001, a, 0, 0);
        downloading = 1'b1;
        write_byte(2 * (CHAR_OFF + a), ~ref_word(CHAR_OFF + a) & 8'hff);
        write_byte(2 * (CHAR_OFF + a) + 1, 8'($random(seed)));
        @(negedge clk);
        downloading = 1'b0;
        n = grants.size();
        read_clients(3'b001, a, 0, 0);
        check("read count", grants.size(), n + 1);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== all.f ====
logic/sdram_pkg.sv
logic/rom_map_pkg.sv
logic/rom_slot.sv
logic/slot_arbiter.sv
logic/rom_dwnld.sv
logic/rom_sub.sv
verification/sdram_model.sv
verification/tb_rom_sub.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ROM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_rom_sub -o sim_rom_sub
if [ $? -ne 0 ]; then
    echo "Compile step failed"
    exit 1
fi

./obj_dir/sim_rom_sub > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
